//--- design/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

  localparam int WORD_W = 16;
  localparam int REG_W = 3;  // register index bits
  localparam int N_REGS = 1 << REG_W;
  localparam int PAGE_BITS = 8;  // logical address bits
  localparam int PAGE_WORDS = 1 << PAGE_BITS;
  localparam int ADDR_W = 10;  // 1024 word ram

  // first instruction word layout
  localparam int OP_MSB = 15;
  localparam int OP_LSB = 8;
  localparam int REG_LSB = 0;

  typedef logic [WORD_W-1:0] word_t;

  typedef enum logic [7:0] {
    OP_JMP       = 8'd1,
    OP_RAM2REG   = 8'd2,
    OP_REG2RAM   = 8'd3,
    OP_NUM2REG   = 8'd4,
    OP_REG_PLUS  = 8'd5,
    OP_REG_MINUS = 8'd6,
    OP_EXIT      = 8'd17
  } opcode_t;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_FETCH1,
    ST_FETCH2,
    ST_DECODE,
    ST_MEM_RD,
    ST_RETIRE
  } stage_t;

endpackage

`default_nettype wire

//--- design/ctx_if.sv
`default_nettype none

interface ctx_if #(
  parameter int N_CTX = 4
);
  import cpu_pkg::*;

  localparam int IDX_W = (N_CTX > 1) ? $clog2(N_CTX) : 1;

  // broadcast write group from the core
  logic [IDX_W-1:0] wr_ctx;  // target context
  logic             pc_we;
  word_t            pc_wdata;
  logic             reg_we;
  logic [REG_W-1:0] reg_idx;
  word_t            reg_wdata;
  logic             exit_set;

  // per context state, one slot each
  word_t pc_rd   [N_CTX];
  word_t regs_rd [N_CTX][N_REGS];
  logic  exited  [N_CTX];

  modport core (
    output wr_ctx, pc_we, pc_wdata, reg_we, reg_idx, reg_wdata, exit_set,
    input  pc_rd, regs_rd
  );

  modport ctx (
    input  wr_ctx, pc_we, pc_wdata, reg_we, reg_idx, reg_wdata, exit_set,
    output pc_rd, regs_rd, exited
  );

  modport sched (
    input exited
  );

endinterface

`default_nettype wire

//--- design/mem_if.sv
`default_nettype none

interface mem_if;
  import cpu_pkg::*;

  logic [ADDR_W-1:0] addr;  // physical address
  word_t             wdata;
  logic              we;
  word_t             rdata;  // valid one cycle after addr

  modport master (
    output addr, wdata, we,
    input  rdata
  );

  modport slave (
    input  addr, wdata, we,
    output rdata
  );

endinterface

`default_nettype wire

//--- design/prog_ram.sv
`default_nettype none

module prog_ram (
  input  logic                        clka,
  input  logic                        load_en,
  input  logic [cpu_pkg::ADDR_W-1:0]  load_addr,
  input  cpu_pkg::word_t              load_data,
  mem_if.slave                        mem
);
  import cpu_pkg::*;

  localparam int DEPTH = 1 << ADDR_W;

  word_t ram [DEPTH];

  // loader wins over the core
  always_ff @(posedge clka) begin
    if (load_en) begin
      ram[load_addr] <= load_data;
    end else if (mem.we) begin
      ram[mem.addr] <= mem.wdata;
    end
  end

  // registered read port
  always_ff @(posedge clka) begin
    mem.rdata <= ram[mem.addr];
  end

endmodule

`default_nettype wire

//--- design/process_context.sv
`default_nettype none

module process_context #(
  parameter int CTX_ID = 0,
  parameter int N_CTX  = 4
) (
  input logic clka,
  input logic rst,
  ctx_if.ctx  bus
);
  import cpu_pkg::*;

  localparam int IDX_W = (N_CTX > 1) ? $clog2(N_CTX) : 1;
  localparam logic [IDX_W-1:0] MY_IDX = IDX_W'(CTX_ID);

  word_t pc_q;
  word_t regs_q [N_REGS];
  logic  exited_q;
  logic  sel;

  assign sel = (bus.wr_ctx == MY_IDX);  // write is for us

  always_ff @(posedge clka) begin
    if (!rst) begin
      pc_q     <= '0;
      exited_q <= 1'b0;
      for (int i = 0; i < N_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (sel) begin
      if (bus.pc_we) begin
        pc_q <= bus.pc_wdata;
      end
      if (bus.reg_we) begin
        regs_q[bus.reg_idx] <= bus.reg_wdata;
      end
      if (bus.exit_set) begin
        exited_q <= 1'b1;  // sticky until reset
      end
    end
  end

  assign bus.pc_rd[CTX_ID]   = pc_q;
  assign bus.regs_rd[CTX_ID] = regs_q;
  assign bus.exited[CTX_ID]  = exited_q;

endmodule

`default_nettype wire

//--- design/ctx_scheduler.sv
`default_nettype none

module ctx_scheduler #(
  parameter int N_CTX = 4,
  parameter int SLICE = 2,
  parameter int CTX_W = 2
) (
  input  logic             clka,
  input  logic             rst,
  input  logic             start,
  input  logic             retire_pulse,
  input  logic             exiting,
  ctx_if.sched             bus,
  output logic [CTX_W-1:0] cur_ctx,
  output logic             go,
  output logic             halted
);

  localparam int CNT_W = (SLICE > 1) ? $clog2(SLICE) : 1;

  logic [CNT_W-1:0] slice_cnt;  // retires in this turn
  logic [CTX_W-1:0] next_ctx;
  logic             next_found;
  logic             slice_done;

  // nearest live context above cur_ctx, wrapping round to cur_ctx itself
  always_comb begin
    next_ctx   = cur_ctx;
    next_found = 1'b0;
    for (int k = N_CTX; k >= 1; k--) begin
      if (!bus.exited[(int'(cur_ctx) + k) % N_CTX]) begin
        next_ctx   = CTX_W'((int'(cur_ctx) + k) % N_CTX);
        next_found = 1'b1;
      end
    end
  end

  assign slice_done = (slice_cnt == CNT_W'(SLICE - 1)) || exiting;

  always_ff @(posedge clka) begin
    if (!rst) begin
      cur_ctx   <= '0;
      slice_cnt <= '0;
      go        <= 1'b0;
      halted    <= 1'b0;
    end else begin
      if (start && !halted) begin
        go <= 1'b1;
      end
      if (retire_pulse) begin
        if (slice_done) begin
          slice_cnt <= '0;
          if (next_found) begin
            cur_ctx <= next_ctx;
          end else begin
            go     <= 1'b0;  // nothing left to run
            halted <= 1'b1;
          end
        end else begin
          slice_cnt <= slice_cnt + 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- design/exec_core.sv
`default_nettype none

module exec_core #(
  parameter int N_CTX = 4,
  parameter int CTX_W = 2
) (
  input  logic                        clka,
  input  logic                        rst,
  input  logic                        go,
  input  logic [CTX_W-1:0]            cur_ctx,
  ctx_if.core                         bus,
  mem_if.master                       mem,
  output logic                        retire_pulse,
  output logic                        exiting,
  output cpu_pkg::opcode_t            retire_op,
  output logic [cpu_pkg::REG_W-1:0]   retire_reg,
  output cpu_pkg::word_t              retire_value
);
  import cpu_pkg::*;

  stage_t               state;
  opcode_t              op_q;  // latched from word 1
  logic [REG_W-1:0]     reg_q;
  word_t                value_q;  // result shown on the trace
  word_t                cur_pc;
  word_t                cur_reg;
  word_t                operand;
  word_t                exec_value;
  logic                 writes_reg;
  logic [PAGE_BITS-1:0] log_addr;
  logic [ADDR_W-1:0]    page_base;

  // pick the running context's pc and addressed register
  always_comb begin
    cur_pc  = '0;
    cur_reg = '0;
    for (int c = 0; c < N_CTX; c++) begin
      if (cur_ctx == CTX_W'(c)) begin
        cur_pc  = bus.pc_rd[c];
        cur_reg = bus.regs_rd[c][reg_q];
      end
    end
  end

  assign operand    = mem.rdata;  // word 2 during ST_DECODE
  assign writes_reg = (op_q == OP_NUM2REG) || (op_q == OP_REG_PLUS) ||
                      (op_q == OP_REG_MINUS);

  always_comb begin
    case (op_q)
      OP_JMP:       exec_value = operand;
      OP_NUM2REG:   exec_value = operand;
      OP_REG_PLUS:  exec_value = cur_reg + operand;  // wraps mod 2^16
      OP_REG_MINUS: exec_value = cur_reg - operand;
      OP_REG2RAM:   exec_value = cur_reg;
      default:      exec_value = '0;
    endcase
  end

  // fixed relocation, one page per context
  assign page_base = ADDR_W'(int'(cur_ctx) * PAGE_WORDS);

  always_comb begin
    case (state)
      ST_FETCH2: log_addr = cur_pc[PAGE_BITS-1:0] + PAGE_BITS'(1);
      ST_DECODE: log_addr = operand[PAGE_BITS-1:0];
      default:   log_addr = cur_pc[PAGE_BITS-1:0];
    endcase
  end

  assign mem.addr  = page_base | ADDR_W'(log_addr);
  assign mem.we    = (state == ST_DECODE) && (op_q == OP_REG2RAM);
  assign mem.wdata = cur_reg;

  // context writes
  assign bus.wr_ctx    = cur_ctx;
  assign bus.pc_we     = (state == ST_DECODE);
  assign bus.pc_wdata  = (op_q == OP_JMP) ? operand : cur_pc + 16'd2;
  assign bus.reg_we    = ((state == ST_DECODE) && writes_reg) || (state == ST_MEM_RD);
  assign bus.reg_idx   = reg_q;
  assign bus.reg_wdata = (state == ST_MEM_RD) ? mem.rdata : exec_value;
  assign bus.exit_set  = (state == ST_DECODE) && (op_q == OP_EXIT);

  always_ff @(posedge clka) begin
    if (!rst) begin
      state <= ST_IDLE;
    end else begin
      case (state)
        ST_IDLE:   if (go) state <= ST_FETCH1;
        ST_FETCH1: state <= ST_FETCH2;
        ST_FETCH2: state <= ST_DECODE;
        ST_DECODE: state <= (op_q == OP_RAM2REG) ? ST_MEM_RD : ST_RETIRE;
        ST_MEM_RD: state <= ST_RETIRE;
        ST_RETIRE: state <= ST_IDLE;  // scheduler settles cur_ctx here
        default:   state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clka) begin
    if (state == ST_FETCH2) begin
      op_q  <= opcode_t'(mem.rdata[OP_MSB:OP_LSB]);
      reg_q <= mem.rdata[REG_LSB +: REG_W];  // upper reg bits ignored
    end
    if (state == ST_DECODE) begin
      value_q <= exec_value;
    end else if (state == ST_MEM_RD) begin
      value_q <= mem.rdata;  // loaded word
    end
  end

  assign retire_pulse = (state == ST_RETIRE);
  assign exiting      = retire_pulse && (op_q == OP_EXIT);
  assign retire_op    = op_q;
  assign retire_reg   = reg_q;
  assign retire_value = value_q;

endmodule

`default_nettype wire

//--- design/cpu_top.sv
`default_nettype none

module cpu_top #(
  parameter int N_CTX = 4,
  parameter int SLICE = 2,
  parameter int CTX_W = 2
) (
  input  logic                        clka,
  input  logic                        rst,
  input  logic                        load_en,
  input  logic [cpu_pkg::ADDR_W-1:0]  load_addr,
  input  cpu_pkg::word_t              load_data,
  input  logic                        start,
  output logic                        retire_valid,
  output logic [CTX_W-1:0]            retire_ctx,
  output cpu_pkg::opcode_t            retire_op,
  output logic [cpu_pkg::REG_W-1:0]   retire_reg,
  output cpu_pkg::word_t              retire_value,
  output logic                        halted
);

  ctx_if #(.N_CTX(N_CTX)) ctx_bus ();
  mem_if                  mem_bus ();

  logic [CTX_W-1:0] cur_ctx;
  logic             go;
  logic             retire_pulse;
  logic             exiting;

  prog_ram u_ram (
    .clka      (clka),
    .load_en   (load_en),
    .load_addr (load_addr),
    .load_data (load_data),
    .mem       (mem_bus)
  );

  ctx_scheduler #(.N_CTX(N_CTX), .SLICE(SLICE), .CTX_W(CTX_W)) u_sched (
    .clka         (clka),
    .rst          (rst),
    .start        (start),
    .retire_pulse (retire_pulse),
    .exiting      (exiting),
    .bus          (ctx_bus),
    .cur_ctx      (cur_ctx),
    .go           (go),
    .halted       (halted)
  );

  exec_core #(.N_CTX(N_CTX), .CTX_W(CTX_W)) u_core (
    .clka         (clka),
    .rst          (rst),
    .go           (go),
    .cur_ctx      (cur_ctx),
    .bus          (ctx_bus),
    .mem          (mem_bus),
    .retire_pulse (retire_pulse),
    .exiting      (exiting),
    .retire_op    (retire_op),
    .retire_reg   (retire_reg),
    .retire_value (retire_value)
  );

  for (genvar g = 0; g < N_CTX; g++) begin : g_ctx
    process_context #(.CTX_ID(g), .N_CTX(N_CTX)) u_ctx (
      .clka (clka),
      .rst  (rst),
      .bus  (ctx_bus)
    );
  end

  // trace strobe, core payload holds until the next fetch
  always_ff @(posedge clka) begin
    if (!rst) begin
      retire_valid <= 1'b0;
    end else begin
      retire_valid <= retire_pulse;
    end
  end

  always_ff @(posedge clka) begin
    if (retire_pulse) begin
      retire_ctx <= cur_ctx;  // owner of this retire
    end
  end

endmodule

`default_nettype wire

//--- dv/cpu_tb.sv
`default_nettype none

module cpu_tb;
  timeunit 1ns;
  timeprecision 1ps;

  import cpu_pkg::*;

  localparam int N_CTX = 4;
  localparam int SLICE = 2;
  localparam int CTX_W = 2;
  localparam int MAX_WAIT = 5000;  // cycles per wait loop

  logic              clka;
  logic              rst;
  logic              load_en;
  logic [ADDR_W-1:0] load_addr;
  word_t             load_data;
  logic              start;
  logic              retire_valid;
  logic [CTX_W-1:0]  retire_ctx;
  opcode_t           retire_op;
  logic [REG_W-1:0]  retire_reg;
  word_t             retire_value;
  logic              halted;

  word_t            image [1 << ADDR_W];  // program and fill image
  logic [CTX_W-1:0] exp_ctx_q [$];
  opcode_t          exp_op_q [$];
  logic [REG_W-1:0] exp_reg_q [$];
  word_t            exp_val_q [$];
  bit               ctx_done [N_CTX];
  bit               started;
  int               n_expected;
  int               n_seen;
  int               value_errors;
  int               timeout_errors;
  int               other_errors;
  integer           seed;

  cpu_top #(.N_CTX(N_CTX), .SLICE(SLICE), .CTX_W(CTX_W)) uut (
    .clka         (clka),
    .rst          (rst),
    .load_en      (load_en),
    .load_addr    (load_addr),
    .load_data    (load_data),
    .start        (start),
    .retire_valid (retire_valid),
    .retire_ctx   (retire_ctx),
    .retire_op    (retire_op),
    .retire_reg   (retire_reg),
    .retire_value (retire_value),
    .halted       (halted)
  );

  initial begin
    clka = 1'b0;
    forever #2 clka = ~clka;
  end

  function automatic void put_instr(input int ctx, input int slot, input logic [7:0] op,
                                    input logic [7:0] r, input word_t opnd);
    int a;
    a = ctx * PAGE_WORDS + 2 * slot;
    image[a]     = {op, r};
    image[a + 1] = opnd;
  endfunction

  function automatic word_t rnd_word();
    return word_t'($random(seed));
  endfunction

  // walks the image the way the machine should and queues every retire
  function automatic void build_expected();
    word_t      m_ram [1 << ADDR_W];
    word_t      m_pc [N_CTX];
    word_t      m_reg [N_CTX][N_REGS];
    bit         m_exit [N_CTX];
    int         cur;
    int         cnt;
    int         steps;
    int         base;
    int         nxt;
    logic [7:0] op_b;
    logic [2:0] r;
    word_t      w1;
    word_t      w2;
    word_t      val;
    bit         done;
    for (int a = 0; a < (1 << ADDR_W); a++) begin
      m_ram[a] = image[a];
    end
    for (int c = 0; c < N_CTX; c++) begin
      m_pc[c]   = '0;
      m_exit[c] = 1'b0;
      for (int k = 0; k < N_REGS; k++) begin
        m_reg[c][k] = '0;
      end
    end
    cur   = 0;
    cnt   = 0;
    steps = 0;
    done  = 1'b0;
    while (!done && steps < 200) begin
      base = cur * PAGE_WORDS;
      w1   = m_ram[base + int'(m_pc[cur][7:0])];
      w2   = m_ram[base + ((int'(m_pc[cur][7:0]) + 1) % PAGE_WORDS)];
      op_b = w1[15:8];
      r    = w1[2:0];  // upper reg bits unused
      val  = '0;
      m_pc[cur] = m_pc[cur] + 16'd2;
      case (opcode_t'(op_b))
        OP_JMP: begin
          m_pc[cur] = w2;
          val       = w2;
        end
        OP_RAM2REG: begin
          val          = m_ram[base + int'(w2[7:0])];
          m_reg[cur][r] = val;
        end
        OP_REG2RAM: begin
          val                          = m_reg[cur][r];
          m_ram[base + int'(w2[7:0])] = val;
        end
        OP_NUM2REG: begin
          val           = w2;
          m_reg[cur][r] = val;
        end
        OP_REG_PLUS: begin
          val           = m_reg[cur][r] + w2;
          m_reg[cur][r] = val;
        end
        OP_REG_MINUS: begin
          val           = m_reg[cur][r] - w2;
          m_reg[cur][r] = val;
        end
        OP_EXIT: m_exit[cur] = 1'b1;
        default: ;  // no-op
      endcase
      exp_ctx_q.push_back(CTX_W'(cur));
      exp_op_q.push_back(opcode_t'(op_b));
      exp_reg_q.push_back(r);
      exp_val_q.push_back(val);
      steps++;
      if (cnt == SLICE - 1 || op_b == OP_EXIT) begin
        cnt = 0;
        nxt = -1;
        for (int k = 1; k <= N_CTX; k++) begin
          if (nxt < 0 && !m_exit[(cur + k) % N_CTX]) begin
            nxt = (cur + k) % N_CTX;
          end
        end
        if (nxt < 0) begin
          done = 1'b1;  // everyone has exited
        end else begin
          cur = nxt;
        end
      end else begin
        cnt++;
      end
    end
    n_expected = steps;
  endfunction

  task automatic check_retire(input logic [CTX_W-1:0] got_ctx, input logic [CTX_W-1:0] exp_ctx,
                              input opcode_t got_op, input opcode_t exp_op,
                              input logic [REG_W-1:0] got_reg, input logic [REG_W-1:0] exp_reg,
                              input word_t got_val, input word_t exp_val);
    if (got_ctx !== exp_ctx) begin
      value_errors++;
      $display("FAILED retire_ctx got %h exp %h", got_ctx, exp_ctx);
    end
    if (got_op !== exp_op) begin
      value_errors++;
      $display("FAILED retire_op got %h exp %h", got_op, exp_op);
    end
    if (got_reg !== exp_reg) begin
      value_errors++;
      $display("FAILED retire_reg got %h exp %h", got_reg, exp_reg);
    end
    if (got_val !== exp_val) begin
      value_errors++;
      $display("FAILED retire_value got %h exp %h", got_val, exp_val);
    end
  endtask

  task automatic check_halt(input logic got, input logic exp);
    if (got !== exp) begin
      value_errors++;
      $display("FAILED halted got %h exp %h", got, exp);
    end
  endtask

  task automatic wait_halted();
    int n;
    n = 0;
    while (halted !== 1'b1 && n < MAX_WAIT) begin
      @(negedge clka);
      n++;
    end
    if (halted !== 1'b1) begin
      timeout_errors++;
      $display("timed out waiting for the machine to halt");
    end
  endtask

  task automatic wait_retires();
    int n;
    n = 0;
    while (n_seen < n_expected && n < MAX_WAIT) begin
      @(negedge clka);
      n++;
    end
    if (n_seen < n_expected) begin
      timeout_errors++;
      $display("timed out with %0d of %0d retires seen", n_seen, n_expected);
    end
  endtask

  // compare process samples at the falling edge
  always @(negedge clka) begin
    if (rst && retire_valid) begin
      if (!started) begin
        other_errors++;
        $display("retire seen before start");
      end else if (exp_ctx_q.size() == 0) begin
        other_errors++;
        $display("unexpected retire from context %0d", retire_ctx);
      end else begin
        if (ctx_done[retire_ctx]) begin
          other_errors++;
          $display("context %0d retired after its exit", retire_ctx);
        end
        check_retire(retire_ctx, exp_ctx_q.pop_front(), retire_op, exp_op_q.pop_front(),
                     retire_reg, exp_reg_q.pop_front(), retire_value, exp_val_q.pop_front());
        if (retire_op == OP_EXIT) begin
          ctx_done[retire_ctx] = 1'b1;
        end
        n_seen++;
      end
    end
  end

  initial begin
    rst            = 1'b0;
    load_en        = 1'b0;
    load_addr      = '0;
    load_data      = '0;
    start          = 1'b0;
    started        = 1'b0;
    n_seen         = 0;
    value_errors   = 0;
    timeout_errors = 0;
    other_errors   = 0;
    seed           = 32'he948b359;
    for (int c = 0; c < N_CTX; c++) begin
      ctx_done[c] = 1'b0;
    end

    for (int a = 0; a < (1 << ADDR_W); a++) begin
      image[a] = word_t'(a * 16'h0105) ^ 16'h3c5a;  // odd multiplier keeps every word unique
    end
    // ctx 0 does arithmetic then stores and loads back at 0x80
    put_instr(0, 0, OP_NUM2REG, 8'h01, rnd_word());
    put_instr(0, 1, OP_REG_PLUS, 8'h01, rnd_word());
    put_instr(0, 2, OP_REG_MINUS, 8'h01, rnd_word());
    put_instr(0, 3, OP_REG2RAM, 8'h01, 16'h0080);
    put_instr(0, 4, OP_RAM2REG, 8'h02, 16'h0080);
    put_instr(0, 5, OP_EXIT, 8'h00, 16'h0000);
    // ctx 1 stores its own value at the same logical address
    put_instr(1, 0, OP_NUM2REG, 8'h01, rnd_word());
    put_instr(1, 1, OP_REG_MINUS, 8'h01, rnd_word());
    put_instr(1, 2, OP_REG2RAM, 8'h01, 16'h0080);
    put_instr(1, 3, OP_RAM2REG, 8'h03, 16'h0080);
    put_instr(1, 4, OP_REG_PLUS, 8'h03, 16'hffff);  // forces a wrap
    put_instr(1, 5, OP_EXIT, 8'h00, 16'h0000);
    // ctx 2 jumps over slot 1 and exits mid turn
    put_instr(2, 0, OP_JMP, 8'h00, 16'h0004);
    put_instr(2, 1, OP_NUM2REG, 8'h00, 16'hdead);
    put_instr(2, 2, 8'h09, 8'h05, rnd_word());
    put_instr(2, 3, OP_EXIT, 8'h00, 16'h0000);
    // ctx 3 outlives the others
    put_instr(3, 0, OP_NUM2REG, 8'h0f, rnd_word());  // only r7 bits used
    put_instr(3, 1, OP_REG_PLUS, 8'h07, rnd_word());
    put_instr(3, 2, 8'h00, 8'h00, 16'h1234);
    put_instr(3, 3, OP_REG_PLUS, 8'h07, rnd_word());
    put_instr(3, 4, OP_REG_MINUS, 8'h07, rnd_word());
    put_instr(3, 5, OP_NUM2REG, 8'h01, rnd_word());
    put_instr(3, 6, OP_REG_MINUS, 8'h01, rnd_word());
    put_instr(3, 7, OP_EXIT, 8'h00, 16'h0000);
    build_expected();

    repeat (8) @(posedge clka);
    rst <= 1'b1;
    @(negedge clka);
    check_halt(halted, 1'b0);
    if (retire_valid !== 1'b0) begin
      value_errors++;
      $display("FAILED retire_valid got %h exp %h", retire_valid, 1'b0);
    end

    for (int a = 0; a < (1 << ADDR_W); a++) begin
      @(posedge clka);
      load_en   <= 1'b1;
      load_addr <= ADDR_W'(a);
      load_data <= image[a];
    end
    @(posedge clka);
    load_en <= 1'b0;
    repeat (4) @(posedge clka);

    started = 1'b1;
    start <= 1'b1;
    @(posedge clka);
    start <= 1'b0;

    wait_halted();
    wait_retires();
    repeat (40) @(negedge clka);  // any late retire shows up here
    check_halt(halted, 1'b1);
    if (exp_ctx_q.size() != 0) begin
      other_errors++;
      $display("%0d expected retires never arrived", exp_ctx_q.size());
    end

    $display("errors: value=%0d timeout=%0d other=%0d", value_errors, timeout_errors,
             other_errors);
    if (value_errors == 0 && timeout_errors == 0 && other_errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- src.f
design/cpu_pkg.sv
design/ctx_if.sv
design/mem_if.sv
design/prog_ram.sv
design/process_context.sv
design/ctx_scheduler.sv
design/exec_core.sv
design/cpu_top.sv
dv/cpu_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f src.f --top-module cpu_tb -o cpu_sim
out=$(./obj_dir/cpu_sim)
echo "$out"

if echo "$out" | grep -q "^TESTS PASSED$"; then
  exit 0
fi
exit 1
